//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ddr_bridge
FILELIST  ?= ddr_bridge.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- ddr_bridge.f
hdl/ddr_bridge_pkg.sv
hdl/reset_seq.sv
hdl/host_arbiter.sv
hdl/lane_fifo.sv
hdl/line_packer.sv
hdl/line_memory.sv
hdl/ddr_bridge_top.sv
test/bridge_asserts.sv
test/bridge_checker.sv
test/tb_ddr_bridge.sv

//--- hdl/ddr_bridge_pkg.sv
package ddr_bridge_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  localparam int host_data_w = 32;  // host word
  localparam int line_data_w = 128; // memory line
  localparam int lane_count  = 4;   // words per line
  localparam int lane_sel_w  = 2;   // addr bits 3:2
  localparam int host_strb_w = 4;   // one bit per host byte
  localparam int line_strb_w = 16;  // one bit per line byte
  localparam int addr_w      = 32;  // host byte address

  // ------------------------------------------------------------
  // sizes
  // ------------------------------------------------------------
  localparam int mem_lines   = 64;  // lines in the line store
  localparam int line_idx_w  = 6;   // addr bits 9:4
  localparam int fifo_depth  = 2;   // lane FIFO entries
  localparam int lock_wait_w = 8;   // top bit set after 128 locked cycles

  // host seen by the bridge
  typedef enum logic {
    port_cpu = 1'b0,
    port_dbg = 1'b1
  } port_sel_e;

  // reset sequencer
  typedef enum logic [1:0] {
    rst_wait_lock = 2'd0,           // lock low, counter cleared
    rst_count     = 2'd1,           // lock high, counting
    rst_ready     = 2'd2            // memory side released
  } rst_state_e;

endpackage

//--- hdl/ddr_bridge_top.sv
`timescale 1ns/10ps

module ddr_bridge_top (
  input  logic                                 sys_clk,
  input  logic                                 sys_rstn,
  input  logic                                 clk_locked,
  input  ddr_bridge_pkg::port_sel_e            host_sel,
  input  logic [ddr_bridge_pkg::addr_w-1:0]      cpu_waddr,
  input  logic [ddr_bridge_pkg::host_data_w-1:0] cpu_wdata,
  input  logic [ddr_bridge_pkg::host_strb_w-1:0] cpu_wstrb,
  input  logic                                 cpu_wvalid,
  output logic                                 cpu_wready,
  output logic                                 cpu_bvalid,
  input  logic                                 cpu_bready,
  input  logic [ddr_bridge_pkg::addr_w-1:0]      cpu_araddr,
  input  logic                                 cpu_arvalid,
  output logic                                 cpu_arready,
  output logic [ddr_bridge_pkg::host_data_w-1:0] cpu_rdata,
  output logic                                 cpu_rvalid,
  input  logic                                 cpu_rready,
  input  logic [ddr_bridge_pkg::addr_w-1:0]      dbg_waddr,
  input  logic [ddr_bridge_pkg::host_data_w-1:0] dbg_wdata,
  input  logic [ddr_bridge_pkg::host_strb_w-1:0] dbg_wstrb,
  input  logic                                 dbg_wvalid,
  output logic                                 dbg_wready,
  output logic                                 dbg_bvalid,
  input  logic                                 dbg_bready,
  input  logic [ddr_bridge_pkg::addr_w-1:0]      dbg_araddr,
  input  logic                                 dbg_arvalid,
  output logic                                 dbg_arready,
  output logic [ddr_bridge_pkg::host_data_w-1:0] dbg_rdata,
  output logic                                 dbg_rvalid,
  input  logic                                 dbg_rready
);
  import ddr_bridge_pkg::*;

  logic                   mem_ready;          // also the memory-side reset

  // arbiter to packer, host word view
  logic [addr_w-1:0]      h_waddr;
  logic [host_data_w-1:0] h_wdata;
  logic [host_strb_w-1:0] h_wstrb;
  logic                   h_wvalid;
  logic                   h_wready;
  logic                   h_bvalid;
  logic                   h_bready;
  logic [addr_w-1:0]      h_araddr;
  logic                   h_arvalid;
  logic                   h_arready;
  logic [host_data_w-1:0] h_rdata;
  logic                   h_rvalid;
  logic                   h_rready;

  // packer to memory, line view
  logic [line_idx_w-1:0]  m_waddr;
  logic [line_data_w-1:0] m_wdata;
  logic [line_strb_w-1:0] m_wstrb;
  logic                   m_wvalid;
  logic                   m_wready;
  logic                   m_bvalid;
  logic                   m_bready;
  logic [line_idx_w-1:0]  m_araddr;
  logic                   m_arvalid;
  logic                   m_arready;
  logic [line_data_w-1:0] m_rdata;
  logic                   m_rvalid;
  logic                   m_rready;

  reset_seq reset_seq_inst (.*);

  host_arbiter host_arbiter_inst (.*);

  line_packer line_packer_inst (.*);

  line_memory #(.lines(mem_lines)) line_memory_inst (
    .sys_rstn (mem_ready),                    // held until lock settles
    .*
  );

endmodule

//--- hdl/host_arbiter.sv
`timescale 1ns/10ps

module host_arbiter (
  input  logic                                 sys_clk,
  input  logic                                 sys_rstn,
  input  ddr_bridge_pkg::port_sel_e            host_sel,
  input  logic [ddr_bridge_pkg::addr_w-1:0]      cpu_waddr,
  input  logic [ddr_bridge_pkg::host_data_w-1:0] cpu_wdata,
  input  logic [ddr_bridge_pkg::host_strb_w-1:0] cpu_wstrb,
  input  logic                                 cpu_wvalid,
  output logic                                 cpu_wready,
  output logic                                 cpu_bvalid,
  input  logic                                 cpu_bready,
  input  logic [ddr_bridge_pkg::addr_w-1:0]      cpu_araddr,
  input  logic                                 cpu_arvalid,
  output logic                                 cpu_arready,
  output logic [ddr_bridge_pkg::host_data_w-1:0] cpu_rdata,
  output logic                                 cpu_rvalid,
  input  logic                                 cpu_rready,
  input  logic [ddr_bridge_pkg::addr_w-1:0]      dbg_waddr,
  input  logic [ddr_bridge_pkg::host_data_w-1:0] dbg_wdata,
  input  logic [ddr_bridge_pkg::host_strb_w-1:0] dbg_wstrb,
  input  logic                                 dbg_wvalid,
  output logic                                 dbg_wready,
  output logic                                 dbg_bvalid,
  input  logic                                 dbg_bready,
  input  logic [ddr_bridge_pkg::addr_w-1:0]      dbg_araddr,
  input  logic                                 dbg_arvalid,
  output logic                                 dbg_arready,
  output logic [ddr_bridge_pkg::host_data_w-1:0] dbg_rdata,
  output logic                                 dbg_rvalid,
  input  logic                                 dbg_rready,
  output logic [ddr_bridge_pkg::addr_w-1:0]      h_waddr,
  output logic [ddr_bridge_pkg::host_data_w-1:0] h_wdata,
  output logic [ddr_bridge_pkg::host_strb_w-1:0] h_wstrb,
  output logic                                 h_wvalid,
  input  logic                                 h_wready,
  input  logic                                 h_bvalid,
  output logic                                 h_bready,
  output logic [ddr_bridge_pkg::addr_w-1:0]      h_araddr,
  output logic                                 h_arvalid,
  input  logic                                 h_arready,
  input  logic [ddr_bridge_pkg::host_data_w-1:0] h_rdata,
  input  logic                                 h_rvalid,
  output logic                                 h_rready
);
  import ddr_bridge_pkg::*;

  port_sel_e                             grant;
  logic [$clog2(2 * fifo_depth + 1)-1:0] outstanding; // both directions
  logic                                  use_dbg;
  logic                                  req_open;
  logic [1:0]                            req_acc;
  logic [1:0]                            rsp_acc;

  assign use_dbg  = (grant == port_dbg);
  assign req_open = (host_sel == grant);      // no new requests while a switch waits

  // ------------------------------------------------------------
  // requests from the granted host
  // ------------------------------------------------------------
  assign h_waddr   = use_dbg ? dbg_waddr : cpu_waddr;
  assign h_wdata   = use_dbg ? dbg_wdata : cpu_wdata;
  assign h_wstrb   = use_dbg ? dbg_wstrb : cpu_wstrb;
  assign h_wvalid  = (use_dbg ? dbg_wvalid : cpu_wvalid) && req_open;
  assign h_araddr  = use_dbg ? dbg_araddr : cpu_araddr;
  assign h_arvalid = (use_dbg ? dbg_arvalid : cpu_arvalid) && req_open;
  assign h_bready  = use_dbg ? dbg_bready : cpu_bready;
  assign h_rready  = use_dbg ? dbg_rready : cpu_rready;

  // responses and readies back to the granted host only
  assign cpu_wready  = !use_dbg && req_open && h_wready;
  assign dbg_wready  = use_dbg && req_open && h_wready;
  assign cpu_arready = !use_dbg && req_open && h_arready;
  assign dbg_arready = use_dbg && req_open && h_arready;
  assign cpu_bvalid  = !use_dbg && h_bvalid;
  assign dbg_bvalid  = use_dbg && h_bvalid;
  assign cpu_rvalid  = !use_dbg && h_rvalid;
  assign dbg_rvalid  = use_dbg && h_rvalid;
  assign cpu_rdata   = use_dbg ? '0 : h_rdata; // idle host reads zero
  assign dbg_rdata   = use_dbg ? h_rdata : '0;

  assign req_acc = {1'b0, h_wvalid && h_wready} + {1'b0, h_arvalid && h_arready};
  assign rsp_acc = {1'b0, h_bvalid && h_bready} + {1'b0, h_rvalid && h_rready};

  always_ff @(posedge sys_clk or negedge sys_rstn) begin
    if (!sys_rstn) begin
      grant       <= port_cpu;
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + req_acc - rsp_acc;
      if (outstanding == 0 && !req_open)
        grant <= host_sel;                    // switch only when drained
    end
  end

endmodule

//--- hdl/lane_fifo.sv
`timescale 1ns/10ps

module lane_fifo #(
  parameter int width = 2,
  parameter int depth = 2                   // power of two
) (
  input  logic             sys_clk,
  input  logic             sys_rstn,
  input  logic             push,
  input  logic [width-1:0] push_data,
  input  logic             pop,
  output logic [width-1:0] pop_data,
  output logic             full,
  output logic             empty
);

  logic [width-1:0]        mem [depth];     // payload, no reset
  logic [$clog2(depth):0]  wr_ptr;          // extra bit tells full from empty
  logic [$clog2(depth):0]  rd_ptr;
  logic [$clog2(depth):0]  fill;

  assign fill     = wr_ptr - rd_ptr;
  assign full     = (fill == depth);
  assign empty    = (fill == 0);
  assign pop_data = mem[rd_ptr[$clog2(depth)-1:0]]; // head, valid when !empty

  always_ff @(posedge sys_clk or negedge sys_rstn) begin
    if (!sys_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push && !full)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop && !empty)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (push && !full)
      mem[wr_ptr[$clog2(depth)-1:0]] <= push_data;
  end

endmodule

//--- hdl/line_memory.sv
`timescale 1ns/10ps

module line_memory #(
  parameter int lines = ddr_bridge_pkg::mem_lines
) (
  input  logic                                 sys_clk,
  input  logic                                 sys_rstn,
  input  logic [ddr_bridge_pkg::line_idx_w-1:0]  m_waddr,
  input  logic [ddr_bridge_pkg::line_data_w-1:0] m_wdata,
  input  logic [ddr_bridge_pkg::line_strb_w-1:0] m_wstrb,
  input  logic                                 m_wvalid,
  output logic                                 m_wready,
  output logic                                 m_bvalid,
  input  logic                                 m_bready,
  input  logic [ddr_bridge_pkg::line_idx_w-1:0]  m_araddr,
  input  logic                                 m_arvalid,
  output logic                                 m_arready,
  output logic [ddr_bridge_pkg::line_data_w-1:0] m_rdata,
  output logic                                 m_rvalid,
  input  logic                                 m_rready
);
  import ddr_bridge_pkg::*;

  logic [line_data_w-1:0] mem [lines];      // line store
  logic                   w_acc;
  logic                   ar_acc;

  // accept while the response slot is free or being emptied
  assign m_wready  = !m_bvalid || m_bready;
  assign m_arready = !m_rvalid || m_rready;
  assign w_acc     = m_wvalid && m_wready;
  assign ar_acc    = m_arvalid && m_arready;

  // ------------------------------------------------------------
  // response flags, held under back-pressure
  // ------------------------------------------------------------
  always_ff @(posedge sys_clk or negedge sys_rstn) begin
    if (!sys_rstn) begin
      m_bvalid <= 1'b0;
      m_rvalid <= 1'b0;
    end else begin
      if (w_acc)
        m_bvalid <= 1'b1;                   // one cycle after accept
      else if (m_bready)
        m_bvalid <= 1'b0;
      if (ar_acc)
        m_rvalid <= 1'b1;
      else if (m_rready)
        m_rvalid <= 1'b0;
    end
  end

  // byte writes and registered read data
  always_ff @(posedge sys_clk) begin
    for (int b = 0; b < line_strb_w; b++) begin
      if (w_acc && m_wstrb[b])
        mem[m_waddr][b*8 +: 8] <= m_wdata[b*8 +: 8];
    end
    if (ar_acc)
      m_rdata <= mem[m_araddr];             // stays put until next accept
  end

endmodule

//--- hdl/line_packer.sv
`timescale 1ns/10ps

module line_packer (
  input  logic                                 sys_clk,
  input  logic                                 sys_rstn,
  input  logic                                 mem_ready,
  input  logic [ddr_bridge_pkg::addr_w-1:0]      h_waddr,
  input  logic [ddr_bridge_pkg::host_data_w-1:0] h_wdata,
  input  logic [ddr_bridge_pkg::host_strb_w-1:0] h_wstrb,
  input  logic                                 h_wvalid,
  output logic                                 h_wready,
  output logic                                 h_bvalid,
  input  logic                                 h_bready,
  input  logic [ddr_bridge_pkg::addr_w-1:0]      h_araddr,
  input  logic                                 h_arvalid,
  output logic                                 h_arready,
  output logic [ddr_bridge_pkg::host_data_w-1:0] h_rdata,
  output logic                                 h_rvalid,
  input  logic                                 h_rready,
  output logic [ddr_bridge_pkg::line_idx_w-1:0]  m_waddr,
  output logic [ddr_bridge_pkg::line_data_w-1:0] m_wdata,
  output logic [ddr_bridge_pkg::line_strb_w-1:0] m_wstrb,
  output logic                                 m_wvalid,
  input  logic                                 m_wready,
  input  logic                                 m_bvalid,
  output logic                                 m_bready,
  output logic [ddr_bridge_pkg::line_idx_w-1:0]  m_araddr,
  output logic                                 m_arvalid,
  input  logic                                 m_arready,
  input  logic [ddr_bridge_pkg::line_data_w-1:0] m_rdata,
  input  logic                                 m_rvalid,
  output logic                                 m_rready
);
  import ddr_bridge_pkg::*;

  logic [lane_sel_w-1:0] w_lane;
  logic [lane_sel_w-1:0] r_lane;            // read FIFO head
  logic                  wf_full;
  logic                  wf_empty;
  logic                  rf_full;
  logic                  rf_empty;
  logic                  w_open;
  logic                  ar_open;

  // ------------------------------------------------------------
  // write request, word placed into its lane
  // ------------------------------------------------------------
  assign w_lane   = h_waddr[2 +: lane_sel_w];
  assign w_open   = mem_ready && !wf_full;
  assign h_wready = m_wready && w_open;
  assign m_wvalid = h_wvalid && w_open;
  assign m_waddr  = h_waddr[2 + lane_sel_w +: line_idx_w];
  assign m_wdata  = {lane_count{h_wdata}};  // same word in every lane
  assign m_wstrb  = line_strb_w'(h_wstrb) << (w_lane * host_strb_w);

  // write response only against a tracked transfer
  assign h_bvalid = m_bvalid && !wf_empty;
  assign m_bready = h_bready && !wf_empty;

  lane_fifo #(.width(host_strb_w + lane_sel_w), .depth(fifo_depth)) wr_fifo_inst (
    .sys_clk   (sys_clk),
    .sys_rstn  (sys_rstn),
    .push      (h_wvalid && h_wready),
    .push_data ({h_wstrb, w_lane}),
    .pop       (m_bvalid && h_bready),
    .pop_data  (),                          // b channel carries no payload
    .full      (wf_full),
    .empty     (wf_empty)
  );

  // ------------------------------------------------------------
  // read request, lane kept for the return
  // ------------------------------------------------------------
  assign ar_open   = mem_ready && !rf_full;
  assign h_arready = m_arready && ar_open;
  assign m_arvalid = h_arvalid && ar_open;
  assign m_araddr  = h_araddr[2 + lane_sel_w +: line_idx_w];

  assign h_rvalid = m_rvalid && !rf_empty;
  assign m_rready = h_rready && !rf_empty;
  assign h_rdata  = m_rdata[r_lane * host_data_w +: host_data_w]; // slice by head

  lane_fifo #(.width(lane_sel_w), .depth(fifo_depth)) rd_fifo_inst (
    .sys_clk   (sys_clk),
    .sys_rstn  (sys_rstn),
    .push      (h_arvalid && h_arready),
    .push_data (h_araddr[2 +: lane_sel_w]),
    .pop       (m_rvalid && h_rready),
    .pop_data  (r_lane),
    .full      (rf_full),
    .empty     (rf_empty)
  );

endmodule

//--- hdl/reset_seq.sv
`timescale 1ns/10ps

module reset_seq (
  input  logic sys_clk,
  input  logic sys_rstn,
  input  logic clk_locked,
  output logic mem_ready
);
  import ddr_bridge_pkg::*;

  rst_state_e             state;
  logic [lock_wait_w-1:0] lock_cnt;
  logic [lock_wait_w-1:0] lock_nxt;

  assign lock_nxt = lock_cnt + 1'b1;

  always_ff @(posedge sys_clk or negedge sys_rstn) begin
    if (!sys_rstn) begin
      state     <= rst_wait_lock;
      lock_cnt  <= '0;
      mem_ready <= 1'b0;
    end else if (!clk_locked) begin       // lock lost, start over
      state     <= rst_wait_lock;
      lock_cnt  <= '0;
      mem_ready <= 1'b0;
    end else begin
      case (state)
        rst_wait_lock, rst_count: begin
          lock_cnt  <= lock_nxt;           // first locked cycle gives 1
          mem_ready <= lock_nxt[lock_wait_w-1]; // 128th cycle
          state     <= lock_nxt[lock_wait_w-1] ? rst_ready : rst_count;
        end
        default: begin
          state     <= rst_ready;          // hold until lock drops
          mem_ready <= 1'b1;
        end
      endcase
    end
  end

endmodule

//--- test/bridge_asserts.sv
`timescale 1ns/10ps

module bridge_asserts (
  input logic        sys_clk,
  input logic        sys_rstn,
  input logic        mem_ready,
  input logic        h_wready,
  input logic        h_arready,
  input logic        h_bvalid,
  input logic        h_bready,
  input logic        h_rvalid,
  input logic        h_rready,
  input logic [31:0] h_rdata
);

  int fail_cnt = 0;                          // read back by the testbench

  // a held write response blocks the next write request
  a_w_stall: assert property (@(posedge sys_clk) disable iff (!sys_rstn)
    h_bvalid && !h_bready |-> !h_wready)
    else begin
      $error("write ready high while its response was held");
      fail_cnt++;
    end

  a_b_hold: assert property (@(posedge sys_clk) disable iff (!sys_rstn || !mem_ready)
    h_bvalid && !h_bready |=> h_bvalid)
    else begin
      $error("write response dropped before it was taken");
      fail_cnt++;
    end

  a_r_hold: assert property (@(posedge sys_clk) disable iff (!sys_rstn || !mem_ready)
    h_rvalid && !h_rready |=> h_rvalid && $stable(h_rdata))
    else begin
      $error("read response changed before it was taken");
      fail_cnt++;
    end

  // same for reads
  a_r_stall: assert property (@(posedge sys_clk) disable iff (!sys_rstn)
    h_rvalid && !h_rready |-> !h_arready)
    else begin
      $error("read ready high while its response was held");
      fail_cnt++;
    end

endmodule

bind line_packer bridge_asserts bridge_asserts_inst (.*);

//--- test/bridge_checker.sv
`timescale 1ns/10ps

module bridge_checker (
  input logic        sys_clk,
  input logic        sys_rstn,
  input logic        cpu_bvalid,
  input logic        cpu_bready,
  input logic        cpu_rvalid,
  input logic        cpu_rready,
  input logic [31:0] cpu_rdata,
  input logic        dbg_bvalid,
  input logic        dbg_bready,
  input logic        dbg_rvalid,
  input logic        dbg_rready,
  input logic [31:0] dbg_rdata
);

  logic [31:0] exp_q [$];                    // expected read words, in order
  int          pending_b = 0;                // writes still owed a response
  int          b_seen    = 0;
  int          r_seen    = 0;
  int          errors    = 0;

  task expect_read(input logic [31:0] word);
    exp_q.push_back(word);
  endtask

  task expect_write();
    pending_b++;
  endtask

  task check_read(input string name, input logic [31:0] got);
    logic [31:0] exp;
    r_seen++;
    if (exp_q.size() == 0) begin
      $display("%0t: read response on %s with no read outstanding", $time, name);
      errors++;
    end else begin
      exp = exp_q.pop_front();
      if (got !== exp) begin
        $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        errors++;
      end
    end
  endtask

  // ------------------------------------------------------------
  // response handshakes, sampled at the edge
  // ------------------------------------------------------------
  always @(posedge sys_clk) begin
    if (sys_rstn) begin
      if ((cpu_bvalid && cpu_bready) || (dbg_bvalid && dbg_bready)) begin
        b_seen++;
        if (pending_b == 0) begin
          $display("%0t: write response with no write outstanding", $time);
          errors++;
        end else
          pending_b--;
      end
      if (cpu_rvalid && cpu_rready)
        check_read("cpu_rdata", cpu_rdata);
      if (dbg_rvalid && dbg_rready)
        check_read("dbg_rdata", dbg_rdata);
    end
  end

endmodule

//--- test/tb_ddr_bridge.sv
`timescale 1ns/10ps

module tb_ddr_bridge;
  import ddr_bridge_pkg::*;

  localparam int n_ops          = 256 + 8 + 20 + 80 + 4; // all host transfers
  localparam int timeout_cycles = 8 + 5 + 128 + n_ops * 8;

  logic sys_clk = 1'b0;
  logic sys_rstn, clk_locked;
  port_sel_e host_sel;
  logic [31:0] cpu_waddr, cpu_wdata, cpu_araddr, cpu_rdata;
  logic [31:0] dbg_waddr, dbg_wdata, dbg_araddr, dbg_rdata;
  logic [3:0]  cpu_wstrb, dbg_wstrb;
  logic cpu_wvalid, cpu_wready, cpu_bvalid, cpu_bready, cpu_arvalid, cpu_arready;
  logic cpu_rvalid, cpu_rready;
  logic dbg_wvalid, dbg_wready, dbg_bvalid, dbg_bready, dbg_arvalid, dbg_arready;
  logic dbg_rvalid, dbg_rready;

  logic [31:0] shadow [256];                 // word view of the line store
  logic [31:0] rng = 32'd13;
  logic [31:0] stall_rng = 32'd13;
  logic        stall_mode = 1'b0;            // random bready/rready
  logic        hold_cpu_r = 1'b0;            // cpu rready forced low
  logic        cpu_quiet = 1'b0;             // cpu port must stay idle
  int          w_req = 0, r_req = 0, b_done = 0, r_done = 0;
  int          lock_cycles = 0, cycle_cnt = 0, errors = 0, total;
  logic [31:0] a0, a1, line_base;

  ddr_bridge_top ddr_bridge_top_inst (.*);

  bridge_checker checker_inst (.*);

  always #10 sys_clk = ~sys_clk;             // 20 ns period

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // shadow update on write, expected word on read
  function automatic logic [31:0] ref_word(input logic wr, input logic [31:0] addr,
                                           input logic [31:0] data, input logic [3:0] strb);
    logic [7:0] idx;
    idx = addr[9:2];
    for (int b = 0; b < 4; b++)
      if (wr && strb[b])
        shadow[idx][b*8 +: 8] = data[b*8 +: 8];
    return shadow[idx];
  endfunction

  function automatic logic [31:0] rand_addr(input logic [31:0] r);
    return {22'd0, r[9:2], 2'b00};          // 64 lines, word aligned
  endfunction

  // ------------------------------------------------------------
  // request monitor, reads before writes as the memory does
  // ------------------------------------------------------------
  always @(posedge sys_clk) begin
    if (sys_rstn) begin
      if (cpu_arvalid && cpu_arready) begin
        checker_inst.expect_read(ref_word(1'b0, cpu_araddr, 32'd0, 4'd0));
        r_req++;
      end
      if (dbg_arvalid && dbg_arready) begin
        checker_inst.expect_read(ref_word(1'b0, dbg_araddr, 32'd0, 4'd0));
        r_req++;
      end
      if (cpu_wvalid && cpu_wready) begin
        void'(ref_word(1'b1, cpu_waddr, cpu_wdata, cpu_wstrb));
        checker_inst.expect_write();
        w_req++;
      end
      if (dbg_wvalid && dbg_wready) begin
        void'(ref_word(1'b1, dbg_waddr, dbg_wdata, dbg_wstrb));
        checker_inst.expect_write();
        w_req++;
      end
      if ((cpu_bvalid && cpu_bready) || (dbg_bvalid && dbg_bready))
        b_done++;
      if ((cpu_rvalid && cpu_rready) || (dbg_rvalid && dbg_rready))
        r_done++;
      if (lock_cycles < 128 && (cpu_wready || cpu_arready || dbg_wready || dbg_arready)) begin
        $display("%0t: request ready before the lock had settled", $time);
        errors++;
      end
      if (cpu_quiet && (cpu_bvalid || cpu_rvalid || cpu_wready || cpu_arready)) begin
        $display("%0t: cpu port active while debug holds the bridge", $time);
        errors++;
      end
      if (clk_locked)
        lock_cycles++;
    end
  end

  // response back-pressure
  always @(posedge sys_clk) begin
    stall_rng = xorshift32(stall_rng);
    cpu_bready <= stall_mode ? stall_rng[3] : 1'b1;
    cpu_rready <= !hold_cpu_r && (stall_mode ? stall_rng[7] : 1'b1);
    dbg_bready <= stall_mode ? stall_rng[11] : 1'b1;
    dbg_rready <= stall_mode ? stall_rng[15] : 1'b1;
  end

  always @(posedge sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  task issue_write(input logic dbg, input logic [31:0] addr, input logic [31:0] data,
                   input logic [3:0] strb);
    @(posedge sys_clk);
    if (dbg) begin
      dbg_waddr  <= addr;
      dbg_wdata  <= data;
      dbg_wstrb  <= strb;
      dbg_wvalid <= 1'b1;
    end else begin
      cpu_waddr  <= addr;
      cpu_wdata  <= data;
      cpu_wstrb  <= strb;
      cpu_wvalid <= 1'b1;
    end
    do @(posedge sys_clk); while (!(dbg ? dbg_wready : cpu_wready));
    cpu_wvalid <= 1'b0;
    dbg_wvalid <= 1'b0;
  endtask

  task issue_read(input logic dbg, input logic [31:0] addr);
    @(posedge sys_clk);
    if (dbg) begin
      dbg_araddr  <= addr;
      dbg_arvalid <= 1'b1;
    end else begin
      cpu_araddr  <= addr;
      cpu_arvalid <= 1'b1;
    end
    do @(posedge sys_clk); while (!(dbg ? dbg_arready : cpu_arready));
    cpu_arvalid <= 1'b0;
    dbg_arvalid <= 1'b0;
  endtask

  task drain();                              // every request answered
    @(posedge sys_clk);                      // last request now counted
    while (b_done < w_req || r_done < r_req)
      @(posedge sys_clk);
  endtask

  initial begin
    {sys_rstn, clk_locked, cpu_wvalid, cpu_arvalid, dbg_wvalid, dbg_arvalid} = '0;
    {cpu_waddr, cpu_wdata, cpu_araddr, dbg_waddr, dbg_wdata, dbg_araddr} = '0;
    {cpu_wstrb, dbg_wstrb} = '0;
    {cpu_bready, cpu_rready, dbg_bready, dbg_rready} = '0;
    host_sel = port_cpu;
    repeat (8) @(posedge sys_clk);
    sys_rstn <= 1'b1;
    repeat (5) @(posedge sys_clk);
    clk_locked <= 1'b1;

    for (int i = 0; i < 256; i++) begin      // preload, first one waits on lock
      rng = xorshift32(rng);
      issue_write(1'b0, 32'(i * 4), rng, 4'hf);
      drain();
    end
    rng = xorshift32(rng);
    line_base = {rand_addr(rng)} & 32'h3f0;
    for (int l = 0; l < 4; l++) begin        // all lanes of one line
      rng = xorshift32(rng);
      issue_write(1'b0, line_base + 32'(l * 4), rng, 4'hf);
      issue_read(1'b0, line_base + 32'(l * 4));
      drain();
    end

    for (int i = 0; i < 4; i++) begin        // partial strobes
      rng = xorshift32(rng);
      a0 = rand_addr(rng);
      issue_write(1'b0, a0, xorshift32(rng), rng[23:20]);
      for (int l = 0; l < 4; l++)
        issue_read(1'b0, (a0 & 32'h3f0) + 32'(l * 4));
      drain();
    end

    stall_mode <= 1'b1;
    for (int i = 0; i < 20; i++) begin       // two in flight under back-pressure
      rng = xorshift32(rng);
      a0 = rand_addr(rng);
      a1 = rand_addr(xorshift32(rng));
      issue_write(1'b0, a0, xorshift32(rng + 1), 4'hf);
      issue_write(1'b0, a1, rng, rng[27:24]);
      issue_read(1'b0, a0);
      issue_read(1'b0, a1);
      drain();
    end
    stall_mode <= 1'b0;

    // ------------------------------------------------------------
    // host switch with a cpu read outstanding
    // ------------------------------------------------------------
    hold_cpu_r <= 1'b1;
    issue_read(1'b0, line_base);
    host_sel    <= port_dbg;
    dbg_araddr  <= line_base + 32'd4;
    dbg_arvalid <= 1'b1;
    repeat (6) begin
      @(posedge sys_clk);
      if (dbg_arready) begin
        $display("FAIL t=%0t dbg_arready got 1 expected 0", $time);
        errors++;
      end
    end
    hold_cpu_r <= 1'b0;
    do @(posedge sys_clk); while (!dbg_arready);
    dbg_arvalid <= 1'b0;
    cpu_quiet   <= 1'b1;
    for (int l = 2; l < 4; l++)
      issue_read(1'b1, line_base + 32'(l * 4));
    drain();
    repeat (4) @(posedge sys_clk);

    if (checker_inst.exp_q.size() != 0 || checker_inst.pending_b != 0 ||
        checker_inst.b_seen != w_req || checker_inst.r_seen != r_req) begin
      $display("response count does not match the requests sent");
      errors++;
    end
    total = errors + checker_inst.errors +
            ddr_bridge_top_inst.line_packer_inst.bridge_asserts_inst.fail_cnt;
    $display("errors: testbench %0d checker %0d assertions %0d (writes %0d reads %0d)",
             errors, checker_inst.errors,
             ddr_bridge_top_inst.line_packer_inst.bridge_asserts_inst.fail_cnt,
             w_req, r_req);
    if (total == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
